/* hw/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define XLEN             32
`define REG_COUNT        32
`define CSR_COUNT        8
`define REG_ADDR_W       5
`define CSR_ADDR_W       3

// fixed control-register indices seen outside the decode stage.
`define CSR_STATUS       0
`define CSR_RESULT_BYTES 1

`define OP_R             7'b0110011
`define OP_I             7'b0010011
`define OP_LOAD          7'b0000011
`define OP_STORE         7'b0100011
`define OP_BRANCH        7'b1100011
`define OP_JAL           7'b1101111
`define OP_SYSTEM        7'b1110011

`define ALU_ADD          3'b000
`define ALU_SUB          3'b001
`define ALU_AND          3'b010
`define ALU_OR           3'b011
`define ALU_SLT          3'b101

// system funct3 values for the two control-register writes.
`define F3_CSRW          3'b001
`define F3_CSRWI         3'b101

`define IMM_I            2'b00
`define IMM_S            2'b01
`define IMM_B            2'b10
`define IMM_J            2'b11

`define RES_ALU          2'b00
`define RES_MEM          2'b01
`define RES_PC4          2'b10
`define RES_CSR          2'b11

`endif

/* hw/decode_pkg.sv */
`include "decode_consts.svh"

package decode_pkg;

    // one data word, used for register values, pc and immediates.
    typedef logic [`XLEN-1:0] word_t;

    // index into the integer register file.
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // the immediate format is 00 for I, 01 for S, 10 for B and 11 for J.
    typedef logic [1:0] imm_src_t;

    // operation code handed to the execute stage ALU.
    typedef logic [2:0] alu_ctrl_t;

    // the write-back source is 00 ALU, 01 memory, 10 pc_plus4 or 11 control register.
    typedef logic [1:0] result_src_t;

    // index into the custom control-register file.
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

endpackage

/* hw/control_unit.sv */
`timescale 1ns/1ns

`include "decode_consts.svh"

module control_unit (
    input  logic [6:0]                op,
    input  logic [2:0]                funct3,
    input  logic                      funct7_5,
    output logic                      reg_write,
    output logic                      mem_write,
    output logic                      branch,
    output logic                      jump,
    output logic                      alu_src,
    output decode_pkg::result_src_t   result_src,
    output decode_pkg::alu_ctrl_t     alu_control,
    output decode_pkg::imm_src_t      imm_src,
    output logic                      csr_write,
    output logic                      csr_src
);
    // alu_op picks add (00), sub (01), the R-type funct (10) or the I-type funct (11).
    logic [1:0] alu_op;
    logic       is_csr_op;

    assign is_csr_op = (funct3 == `F3_CSRW) || (funct3 == `F3_CSRWI);

    always_comb begin
        reg_write  = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        alu_src    = 1'b0;
        result_src = `RES_ALU;
        imm_src    = `IMM_I;
        csr_write  = 1'b0;
        csr_src    = 1'b0;
        alu_op     = 2'b00;
        case (op)
            `OP_R: begin
                reg_write = 1'b1;
                alu_op    = 2'b10;
            end
            `OP_I: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = 2'b11;
            end
            `OP_LOAD: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                result_src = `RES_MEM;
            end
            `OP_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = `IMM_S;
            end
            `OP_BRANCH: begin
                branch  = 1'b1;
                imm_src = `IMM_B;
                alu_op  = 2'b01;
            end
            `OP_JAL: begin
                jump       = 1'b1;
                reg_write  = 1'b1;
                result_src = `RES_PC4;
                imm_src    = `IMM_J;
            end
            `OP_SYSTEM: begin
                if (is_csr_op) begin
                    csr_write  = 1'b1;
                    reg_write  = 1'b1;
                    result_src = `RES_CSR;
                    csr_src    = (funct3 == `F3_CSRWI);
                end
            end
            default: ;
        endcase
    end

    // the immediate bit 30 of an I-type add must not turn it into a subtract.
    always_comb begin
        case (alu_op)
            2'b00: alu_control = `ALU_ADD;
            2'b01: alu_control = `ALU_SUB;
            default: begin
                case (funct3)
                    3'b000:  alu_control = (alu_op == 2'b10 && funct7_5) ? `ALU_SUB : `ALU_ADD;
                    3'b010:  alu_control = `ALU_SLT;
                    3'b110:  alu_control = `ALU_OR;
                    3'b111:  alu_control = `ALU_AND;
                    default: alu_control = `ALU_ADD;
                endcase
            end
        endcase
    end
endmodule

/* hw/imm_extend.sv */
`timescale 1ns/1ns

`include "decode_consts.svh"

module imm_extend (
    input  logic [24:0]          instr_hi,
    input  decode_pkg::imm_src_t imm_src,
    output decode_pkg::word_t    imm_ext
);
    // instr_hi[n] holds instruction bit n+7, so instr_hi[24] is the sign bit.
    always_comb begin
        case (imm_src)
            `IMM_I: imm_ext = {{20{instr_hi[24]}}, instr_hi[24:13]};
            `IMM_S: imm_ext = {{20{instr_hi[24]}}, instr_hi[24:18], instr_hi[4:0]};
            `IMM_B: begin
                imm_ext = {{20{instr_hi[24]}}, instr_hi[0], instr_hi[23:18],
                           instr_hi[4:1], 1'b0};
            end
            default: begin
                imm_ext = {{12{instr_hi[24]}}, instr_hi[12:5], instr_hi[13],
                           instr_hi[23:14], 1'b0};
            end
        endcase
    end
endmodule

/* hw/regfile.sv */
`timescale 1ns/1ns

`include "decode_consts.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we3,
    input  decode_pkg::reg_addr_t a1,
    input  decode_pkg::reg_addr_t a2,
    input  decode_pkg::reg_addr_t a3,
    input  decode_pkg::word_t     wd3,
    output decode_pkg::word_t     rd1,
    output decode_pkg::word_t     rd2
);
    import decode_pkg::*;

    word_t regs [`REG_COUNT];

    // the parent hands in an inverted clock, so this edge is the falling edge of the core clock.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we3 && a3 != '0) begin
            regs[a3] <= wd3;
        end
    end

    // x0 is hardwired to zero.
    assign rd1 = (a1 == '0) ? '0 : regs[a1];
    assign rd2 = (a2 == '0) ? '0 : regs[a2];
endmodule

/* hw/csr_file.sv */
`timescale 1ns/1ns

`include "decode_consts.svh"

module csr_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  decode_pkg::csr_addr_t addr,
    input  decode_pkg::word_t     din,
    output decode_pkg::word_t     dout,
    output decode_pkg::word_t     status,
    output decode_pkg::word_t     result_bytes
);
    import decode_pkg::*;

    word_t regs [`CSR_COUNT];

    // written on the inverted clock like the integer register file.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CSR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[addr] <= din;
        end
    end

    assign dout = regs[addr];

    // these two entries are always visible to the rest of the core.
    assign status       = regs[`CSR_STATUS];
    assign result_bytes = regs[`CSR_RESULT_BYTES];
endmodule

/* hw/instr_decode.sv */
`timescale 1ns/1ns

`include "decode_consts.svh"

module instr_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  decode_pkg::word_t       instr,
    input  decode_pkg::word_t       pc,
    input  decode_pkg::word_t       pc_plus4,
    input  decode_pkg::reg_addr_t   rd_w,
    input  decode_pkg::word_t       result_w,
    input  logic                    reg_write_w,
    output logic                    reg_write,
    output logic                    mem_write,
    output logic                    branch,
    output logic                    jump,
    output logic                    alu_src,
    output decode_pkg::result_src_t result_src,
    output decode_pkg::alu_ctrl_t   alu_control,
    output decode_pkg::word_t       rd1,
    output decode_pkg::word_t       rd2,
    output decode_pkg::word_t       imm_ext,
    output decode_pkg::word_t       csr_dout,
    output decode_pkg::word_t       status,
    output decode_pkg::word_t       result_bytes,
    output decode_pkg::reg_addr_t   rs1,
    output decode_pkg::reg_addr_t   rs2,
    output decode_pkg::reg_addr_t   rd,
    output decode_pkg::word_t       pc_d,
    output decode_pkg::word_t       pc_plus4_d
);
    import decode_pkg::*;

    imm_src_t imm_src;
    logic     csr_write;
    logic     csr_src;
    word_t    csr_din;
    logic     clk_n;

    // both register files write on the falling edge so a write-back is readable in the same cycle.
    assign clk_n = ~clk;

    control_unit i_control_unit (
        .op          (instr[6:0]),
        .funct3      (instr[14:12]),
        .funct7_5    (instr[30]),
        .reg_write   (reg_write),
        .mem_write   (mem_write),
        .branch      (branch),
        .jump        (jump),
        .alu_src     (alu_src),
        .result_src  (result_src),
        .alu_control (alu_control),
        .imm_src     (imm_src),
        .csr_write   (csr_write),
        .csr_src     (csr_src)
    );

    regfile i_regfile (
        .clk (clk_n),
        .rst (rst),
        .we3 (reg_write_w),
        .a1  (instr[19:15]),
        .a2  (instr[24:20]),
        .a3  (rd_w),
        .wd3 (result_w),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    imm_extend i_imm_extend (
        .instr_hi (instr[31:7]),
        .imm_src  (imm_src),
        .imm_ext  (imm_ext)
    );

    // the immediate form writes the rs1 field itself, sign-extended.
    assign csr_din = csr_src ? {{(`XLEN-5){instr[19]}}, instr[19:15]} : rd1;

    csr_file i_csr_file (
        .clk          (clk_n),
        .rst          (rst),
        .we           (csr_write),
        .addr         (imm_ext[`CSR_ADDR_W-1:0]),
        .din          (csr_din),
        .dout         (csr_dout),
        .status       (status),
        .result_bytes (result_bytes)
    );

    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign rd         = instr[11:7];
    assign pc_d       = pc;
    assign pc_plus4_d = pc_plus4;
endmodule

/* test/tb_instr_decode.sv */
`timescale 1ns/1ns

`include "decode_consts.svh"

module tb_instr_decode;
    import decode_pkg::*;

    logic        clk;
    logic        rst;
    word_t       instr;
    word_t       pc;
    word_t       pc_plus4;
    reg_addr_t   rd_w;
    word_t       result_w;
    logic        reg_write_w;

    logic        reg_write;
    logic        mem_write;
    logic        branch;
    logic        jump;
    logic        alu_src;
    result_src_t result_src;
    alu_ctrl_t   alu_control;
    word_t       rd1;
    word_t       rd2;
    word_t       imm_ext;
    word_t       csr_dout;
    word_t       status;
    word_t       result_bytes;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       pc_d;
    word_t       pc_plus4_d;

    // raw vector lines are parsed only when each vector is applied.
    string       vec_lines[$];
    string       test_name;
    word_t       v_instr;
    word_t       v_pc;
    word_t       v_pc4;
    reg_addr_t   v_rd_w;
    word_t       v_result;
    logic        v_we;
    logic [9:0]  exp_ctrl;
    word_t       exp_rd1;
    word_t       exp_rd2;
    word_t       exp_imm;
    word_t       exp_dout;
    word_t       exp_status;
    word_t       exp_rbytes;
    int          mismatches = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    instr_decode i_instr_decode (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // the watchdog limit is set once the vectors are known.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic compare_field(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
            mismatches++;
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    code;
        string line;
        fd = $fopen("test/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/decode_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 1 && line[0] != "#") begin
                    vec_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_vector(input int idx, input string text);
        int fields;
        fields = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         test_name, v_instr, v_pc, v_pc4, v_rd_w, v_result, v_we,
                         exp_ctrl, exp_rd1, exp_rd2, exp_imm, exp_dout, exp_status, exp_rbytes);
        if (fields != 14) begin
            $display("test %0d: the vector line could not be parsed", idx);
            tests_failed++;
        end else begin
            mismatches = 0;
            @(posedge clk);
            instr       <= v_instr;
            pc          <= v_pc;
            pc_plus4    <= v_pc4;
            rd_w        <= v_rd_w;
            result_w    <= v_result;
            reg_write_w <= v_we;
            // register writes land at the falling edge, so look just before the next rise.
            @(negedge clk);
            #3;
            compare_field("ctrl", {22'b0, exp_ctrl}, {22'b0, reg_write, mem_write, branch,
                          jump, alu_src, result_src, alu_control});
            compare_field("rd1", exp_rd1, rd1);
            compare_field("rd2", exp_rd2, rd2);
            compare_field("imm_ext", exp_imm, imm_ext);
            compare_field("csr_dout", exp_dout, csr_dout);
            compare_field("status", exp_status, status);
            compare_field("result_bytes", exp_rbytes, result_bytes);
            compare_field("rs1", {27'b0, v_instr[19:15]}, {27'b0, rs1});
            compare_field("rs2", {27'b0, v_instr[24:20]}, {27'b0, rs2});
            compare_field("rd", {27'b0, v_instr[11:7]}, {27'b0, rd});
            compare_field("pc_d", v_pc, pc_d);
            compare_field("pc_plus4_d", v_pc4, pc_plus4_d);
            if (mismatches == 0) begin
                $display("test %s: ok", test_name);
                tests_passed++;
            end else begin
                $display("test %s: %0d mismatches", test_name, mismatches);
                tests_failed++;
            end
        end
    endtask

    // a second reset must clear the entries that the vectors have written.
    task automatic check_reset_clears();
        test_name  = "reset_clears";
        mismatches = 0;
        @(posedge clk);
        rst         <= 1'b1;
        instr       <= '0;
        reg_write_w <= 1'b0;
        repeat (10) @(posedge clk);
        rst   <= 1'b0;
        // add x1, x6, x5 reads two written registers and control register 5.
        instr <= 32'h005300b3;
        @(negedge clk);
        #3;
        compare_field("rd1", 32'h0, rd1);
        compare_field("rd2", 32'h0, rd2);
        compare_field("csr_dout", 32'h0, csr_dout);
        compare_field("status", 32'h0, status);
        compare_field("result_bytes", 32'h0, result_bytes);
        if (mismatches == 0) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d mismatches", test_name, mismatches);
            tests_failed++;
        end
    endtask

    initial begin
        rst         <= 1'b1;
        instr       <= '0;
        pc          <= '0;
        pc_plus4    <= '0;
        rd_w        <= '0;
        result_w    <= '0;
        reg_write_w <= 1'b0;
        read_vectors();
        cycle_limit = 4 * vec_lines.size() + 20;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < vec_lines.size(); i++) begin
            run_vector(i, vec_lines[i]);
        end
        if (vec_lines.size() == 0) begin
            $display("no test vectors were read");
            tests_failed++;
        end else begin
            check_reset_clears();
        end
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end
endmodule

/* test/decode_stimulus.txt */
# name, then inputs instr pc pc_plus4 rd_w result_w reg_write_w, all in hex
# then expected ctrl rd1 rd2 imm_ext csr_dout status result_bytes, ctrl = {levels, res, alu}
reset_idle 00000000 100 104 0 0 0 000 0 0 0 0 0 0
r_add_wr_x5 006280b3 104 108 5 12345678 1 200 12345678 0 6 0 0 0
r_sub_wr_x6 40530133 108 10c 6 fffffff0 1 201 fffffff0 12345678 405 0 0 0
wr_x0 005001b3 10c 110 0 deadbeef 1 200 0 12345678 5 0 0 0
wr_disabled 00638233 110 114 7 cafef00d 0 200 0 fffffff0 6 0 0 0
wr_x31 01f280b3 114 118 1f 80000001 1 200 12345678 80000001 1f 0 0 0
i_or_neg fff2e413 118 11c 0 0 0 223 12345678 80000001 ffffffff 0 0 0
i_slt_pos 7ff32493 11c 120 0 0 0 225 fffffff0 80000001 7ff 0 0 0
i_add_bit30 40000093 120 124 0 0 0 220 0 0 400 0 0 0
load_neg ffc2a503 124 128 0 0 0 228 12345678 0 fffffffc 0 0 0
store_pos 0062aa23 128 12c 0 0 0 120 12345678 fffffff0 14 0 0 0
store_neg fe532c23 12c 130 0 0 0 120 fffffff0 12345678 fffffff8 0 0 0
branch_pos 00628863 130 134 0 0 0 081 12345678 fffffff0 10 0 0 0
branch_neg fe5310e3 134 138 0 0 0 081 fffffff0 12345678 ffffffe0 0 0 0
jal_pos 001000ef 138 13c 0 0 0 250 0 0 800 0 0 0
jal_neg ffdff06f 13c 140 0 0 0 250 80000001 0 fffffffc 0 0 0
csrw_status 00029073 140 144 0 0 0 218 12345678 0 0 12345678 12345678 0
csrw_rbytes 00131073 144 148 0 0 0 218 fffffff0 0 1 fffffff0 12345678 fffffff0
csrwi_rbytes 00155073 148 14c 0 0 0 218 0 0 1 a 12345678 a
csrwi_neg 0059d073 14c 150 0 0 0 218 0 12345678 5 fffffff3 12345678 a
csrw_wrap 00af9073 150 154 0 0 0 218 80000001 0 a 80000001 12345678 a
csrwi_status 000fd073 154 158 0 0 0 218 80000001 0 0 ffffffff ffffffff a
system_other 00000073 158 15c 0 0 0 000 0 0 0 ffffffff ffffffff a
unknown_op 0062807f 15c 160 0 0 0 000 12345678 fffffff0 6 0 ffffffff a
csr_read 00502003 fffffffc 0 0 0 0 228 0 12345678 5 fffffff3 ffffffff a

/* vlog.f */
+incdir+hw
hw/decode_pkg.sv
hw/control_unit.sv
hw/imm_extend.sv
hw/regfile.sv
hw/csr_file.sv
hw/instr_decode.sv
test/tb_instr_decode.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the decode-stage testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the simulation log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f vlog.f --top-module tb_instr_decode -Mdir obj_dir -o sim_decode
	./obj_dir/sim_decode | tee sim.log
	grep -qxF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
